// File: src/hq_pkg.sv
/* host queue shared definitions */

package hq_pkg;

    // descriptor layout
    localparam int DESC_W   = 23;
    localparam int BUFID_W  = 9;
    localparam int LEN_W    = 8;
    localparam int SLOT_W   = 3;
    localparam int TYPE_W   = 3;
    localparam int BUFID_LSB = 0;
    localparam int LEN_LSB   = 9;
    localparam int SLOT_LSB  = 17;
    localparam int TYPE_LSB  = 20;

    // schedule and storage sizes
    localparam int N_SLOTS     = 8;
    localparam int SLOT_CYCLES = 16;
    // prescaler width, covers SLOT_CYCLES-1
    localparam int PRESC_W     = 4;
    localparam int FIFO_DEPTH  = 8;
    localparam int FIFO_AW     = 3;

    // descriptor type field, only ts goes to the slot table
    typedef enum logic [TYPE_W-1:0] {
        PKT_BE  = 3'd0,
        PKT_RC  = 3'd1,
        PKT_TS  = 3'd2,
        PKT_PTP = 3'd3
    } pkt_type_e;

    typedef enum logic [1:0] {
        HIQ_IDLE_S  = 2'd0,
        HIQ_STORE_S = 2'd1,
        HIQ_ACK_S   = 2'd2
    } hiq_state_e;

    typedef enum logic [1:0] {
        IDLE_S              = 2'd0,
        OUTPUT_DESCRIPTOR_S = 2'd1,
        TRANSMIT_WAIT_S     = 2'd2
    } hoq_state_e;

endpackage

// File: src/host_input_queue.sv
/* host input queue */

module host_input_queue (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    // four-phase handshake from the parser
    input  logic                      i_in_req,
    input  logic [hq_pkg::DESC_W-1:0] i_in_desc,
    output logic                      o_in_ack,
    // non-ts path
    output logic                      o_fifo_wr,
    output logic [hq_pkg::DESC_W-1:0] o_fifo_wdata,
    input  logic                      i_fifo_full,
    // ts path
    output logic                      o_slot_wr,
    output logic [hq_pkg::DESC_W-1:0] o_slot_wdata,
    input  logic                      i_slot_busy
);

    hq_pkg::hiq_state_e        state;
    logic [hq_pkg::DESC_W-1:0] desc_q;
    logic                      is_ts;
    logic                      room;

    // type decode on the latched descriptor
    assign is_ts = (hq_pkg::pkt_type_e'(desc_q[hq_pkg::TYPE_LSB +: hq_pkg::TYPE_W])
                    == hq_pkg::PKT_TS);
    // busy is the valid flag of the slot this descriptor targets
    assign room  = is_ts ? !i_slot_busy : !i_fifo_full;

    // write strobes fire in store once the target can take it
    assign o_fifo_wr    = (state == hq_pkg::HIQ_STORE_S) && !is_ts && !i_fifo_full;
    assign o_slot_wr    = (state == hq_pkg::HIQ_STORE_S) && is_ts && !i_slot_busy;
    assign o_fifo_wdata = desc_q;
    assign o_slot_wdata = desc_q;

    // descriptor latch, payload only
    always_ff @(posedge i_clk) begin
        if (state == hq_pkg::HIQ_IDLE_S && i_in_req) begin
            desc_q <= i_in_desc;
        end
    end

    //******************************************************************
    // handshake fsm
    //******************************************************************
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= hq_pkg::HIQ_IDLE_S;
            o_in_ack <= 1'b0;
        end else begin
            case (state)
                hq_pkg::HIQ_IDLE_S: begin
                    if (i_in_req) begin
                        state <= hq_pkg::HIQ_STORE_S;
                    end
                end
                hq_pkg::HIQ_STORE_S: begin
                    // hold here while target full or slot taken
                    if (room) begin
                        state    <= hq_pkg::HIQ_ACK_S;
                        o_in_ack <= 1'b1;
                    end
                end
                hq_pkg::HIQ_ACK_S: begin
                    // wait for parser to drop req
                    if (!i_in_req) begin
                        state    <= hq_pkg::HIQ_IDLE_S;
                        o_in_ack <= 1'b0;
                    end
                end
                default: begin
                    state    <= hq_pkg::HIQ_IDLE_S;
                    o_in_ack <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: src/descriptor_fifo.sv
/* non-ts descriptor fifo */

module descriptor_fifo (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_wr,
    input  logic [hq_pkg::DESC_W-1:0] i_wdata,
    output logic                      o_full,
    input  logic                      i_rd,
    output logic [hq_pkg::DESC_W-1:0] o_rdata,
    output logic                      o_empty
);

    logic [hq_pkg::DESC_W-1:0]  mem [hq_pkg::FIFO_DEPTH];
    logic [hq_pkg::FIFO_AW-1:0] wr_ptr;
    logic [hq_pkg::FIFO_AW-1:0] rd_ptr;
    logic [hq_pkg::FIFO_AW:0]   count;
    logic                       do_wr;
    logic                       do_rd;

    assign o_full  = (count == (hq_pkg::FIFO_AW + 1)'(hq_pkg::FIFO_DEPTH));
    assign o_empty = (count == '0);
    // drop writes when full, reads when empty
    assign do_wr   = i_wr && !o_full;
    assign do_rd   = i_rd && !o_empty;

    // storage and registered read data
    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wdata;
        end
        if (do_rd) begin
            o_rdata <= mem[rd_ptr];
        end
    end

    // pointers and occupancy
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous read and write leaves count as is
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: src/ts_slot_table.sv
/* ts slot table */

module ts_slot_table (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_wr,
    input  logic [hq_pkg::DESC_W-1:0] i_wdata,
    output logic                      o_busy,
    input  logic                      i_tick,
    input  logic [hq_pkg::SLOT_W-1:0] i_cur_slot,
    input  logic                      i_rd,
    output logic                      o_due_any,
    output logic [hq_pkg::DESC_W-1:0] o_rdata
);

    logic [hq_pkg::DESC_W-1:0]  entry [hq_pkg::N_SLOTS];
    logic [hq_pkg::N_SLOTS-1:0] valid;
    logic [hq_pkg::N_SLOTS-1:0] due;
    logic [hq_pkg::SLOT_W-1:0]  wr_slot;
    logic [hq_pkg::SLOT_W-1:0]  rd_slot;

    assign wr_slot   = i_wdata[hq_pkg::SLOT_LSB +: hq_pkg::SLOT_W];
    assign o_busy    = valid[wr_slot];
    assign o_due_any = |due;

    // lowest due slot, scanned from the top down
    always_comb begin
        rd_slot = '0;
        for (int i = hq_pkg::N_SLOTS - 1; i >= 0; i--) begin
            if (due[i]) begin
                rd_slot = hq_pkg::SLOT_W'(i);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_wr) begin
            entry[wr_slot] <= i_wdata;
        end
        if (i_rd) begin
            o_rdata <= entry[rd_slot];
        end
    end

    // flags, tick sees the old valid so a same-edge write waits a round
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid <= '0;
            due   <= '0;
        end else begin
            if (i_tick && valid[i_cur_slot]) begin
                due[i_cur_slot] <= 1'b1;
            end
            if (i_wr) begin
                valid[wr_slot] <= 1'b1;
            end
            if (i_rd && o_due_any) begin
                valid[rd_slot] <= 1'b0;
                due[rd_slot]   <= 1'b0;
            end
        end
    end

endmodule

// File: src/slot_timer.sv
/* schedule slot timer */

module slot_timer (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    output logic                      o_tick,
    output logic [hq_pkg::SLOT_W-1:0] o_cur_slot
);

    logic [hq_pkg::PRESC_W-1:0] presc;
    logic                       wrap;

    assign wrap = (presc == hq_pkg::PRESC_W'(hq_pkg::SLOT_CYCLES - 1));

    // tick pulses together with the new slot number
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            presc      <= '0;
            o_tick     <= 1'b0;
            o_cur_slot <= '0;
        end else begin
            o_tick <= wrap;
            if (wrap) begin
                presc <= '0;
                if (o_cur_slot == hq_pkg::SLOT_W'(hq_pkg::N_SLOTS - 1)) begin
                    o_cur_slot <= '0;
                end else begin
                    o_cur_slot <= o_cur_slot + 1'b1;
                end
            end else begin
                presc <= presc + 1'b1;
            end
        end
    end

endmodule

// File: src/host_output_queue.sv
/* host output queue */

module host_output_queue (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    // non-ts fifo
    input  logic                      i_fifo_empty,
    output logic                      o_fifo_rd,
    input  logic [hq_pkg::DESC_W-1:0] i_fifo_rdata,
    // ts slot table
    input  logic                      i_ts_due,
    output logic                      o_ts_rd,
    input  logic [hq_pkg::DESC_W-1:0] i_ts_rdata,
    // host side
    output logic [hq_pkg::DESC_W-1:0] o_descriptor,
    output logic                      o_descriptor_wr,
    input  logic                      i_descriptor_ready
);

    hq_pkg::hoq_state_e state;
    // source of the pending read, 1 for the slot table
    logic               src_ts;

    // both sources give registered data during the strobe cycle
    assign o_descriptor = o_descriptor_wr ? (src_ts ? i_ts_rdata : i_fifo_rdata) : '0;

    //******************************************************************
    // read and transmit fsm
    //******************************************************************
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state           <= hq_pkg::IDLE_S;
            src_ts          <= 1'b0;
            o_fifo_rd       <= 1'b0;
            o_ts_rd         <= 1'b0;
            o_descriptor_wr <= 1'b0;
        end else begin
            case (state)
                hq_pkg::IDLE_S: begin
                    o_descriptor_wr <= 1'b0;
                    // due ts entry goes first
                    if (i_ts_due) begin
                        o_ts_rd <= 1'b1;
                        src_ts  <= 1'b1;
                        state   <= hq_pkg::OUTPUT_DESCRIPTOR_S;
                    end else if (!i_fifo_empty) begin
                        o_fifo_rd <= 1'b1;
                        src_ts    <= 1'b0;
                        state     <= hq_pkg::OUTPUT_DESCRIPTOR_S;
                    end else begin
                        o_fifo_rd <= 1'b0;
                        o_ts_rd   <= 1'b0;
                    end
                end
                hq_pkg::OUTPUT_DESCRIPTOR_S: begin
                    // read strobe was one cycle, data lands now
                    o_fifo_rd       <= 1'b0;
                    o_ts_rd         <= 1'b0;
                    o_descriptor_wr <= 1'b1;
                    state           <= hq_pkg::TRANSMIT_WAIT_S;
                end
                hq_pkg::TRANSMIT_WAIT_S: begin
                    o_descriptor_wr <= 1'b0;
                    // ready during the strobe cycle counts too
                    if (i_descriptor_ready) begin
                        state <= hq_pkg::IDLE_S;
                    end
                end
                default: begin
                    o_fifo_rd       <= 1'b0;
                    o_ts_rd         <= 1'b0;
                    o_descriptor_wr <= 1'b0;
                    state           <= hq_pkg::IDLE_S;
                end
            endcase
        end
    end

endmodule

// File: src/host_queue_top.sv
/* host descriptor queue top */

module host_queue_top (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_in_req,
    input  logic [hq_pkg::DESC_W-1:0] i_in_desc,
    output logic                      o_in_ack,
    output logic [hq_pkg::DESC_W-1:0] o_descriptor,
    output logic                      o_descriptor_wr,
    input  logic                      i_descriptor_ready
);

    // input queue to storage
    logic                      fifo_wr;
    logic [hq_pkg::DESC_W-1:0] fifo_wdata;
    logic                      fifo_full;
    logic                      slot_wr;
    logic [hq_pkg::DESC_W-1:0] slot_wdata;
    logic                      slot_busy;
    // timer to slot table
    logic                      slot_tick;
    logic [hq_pkg::SLOT_W-1:0] slot_cur;
    // storage to output queue
    logic                      fifo_rd;
    logic                      fifo_empty;
    logic [hq_pkg::DESC_W-1:0] fifo_rdata;
    logic                      ts_rd;
    logic                      ts_due_any;
    logic [hq_pkg::DESC_W-1:0] ts_rdata;

    host_input_queue u_hiq (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_in_req(i_in_req), .i_in_desc(i_in_desc), .o_in_ack(o_in_ack),
        .o_fifo_wr(fifo_wr), .o_fifo_wdata(fifo_wdata), .i_fifo_full(fifo_full),
        .o_slot_wr(slot_wr), .o_slot_wdata(slot_wdata), .i_slot_busy(slot_busy)
    );

    descriptor_fifo u_fifo (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_wr(fifo_wr), .i_wdata(fifo_wdata), .o_full(fifo_full),
        .i_rd(fifo_rd), .o_rdata(fifo_rdata), .o_empty(fifo_empty)
    );

    ts_slot_table u_slots (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_wr(slot_wr), .i_wdata(slot_wdata), .o_busy(slot_busy),
        .i_tick(slot_tick), .i_cur_slot(slot_cur),
        .i_rd(ts_rd), .o_due_any(ts_due_any), .o_rdata(ts_rdata)
    );

    slot_timer u_timer (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .o_tick(slot_tick), .o_cur_slot(slot_cur)
    );

    host_output_queue u_hoq (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_fifo_empty(fifo_empty), .o_fifo_rd(fifo_rd), .i_fifo_rdata(fifo_rdata),
        .i_ts_due(ts_due_any), .o_ts_rd(ts_rd), .i_ts_rdata(ts_rdata),
        .o_descriptor(o_descriptor), .o_descriptor_wr(o_descriptor_wr),
        .i_descriptor_ready(i_descriptor_ready)
    );

endmodule

// File: verif/host_queue_properties.sv
/* host queue protocol checks */

module host_queue_properties (
    input logic                      i_clk,
    input logic                      i_rst_n,
    input logic                      i_in_req,
    input logic                      i_in_ack,
    input logic [hq_pkg::DESC_W-1:0] i_descriptor,
    input logic                      i_descriptor_wr,
    input logic                      i_descriptor_ready,
    input logic                      i_fifo_rd,
    input logic                      i_ts_rd,
    input logic                      i_ts_due_any
);

    int   fail_count = 0;
    // strobe sent, host not ready yet
    logic wait_ready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wait_ready <= 1'b0;
        end else if (i_descriptor_ready) begin
            wait_ready <= 1'b0;
        end else if (i_descriptor_wr) begin
            wait_ready <= 1'b1;
        end
    end

    //******************************************************************
    // reset and input handshake
    //******************************************************************
    a_reset_quiet: assert property (@(posedge i_clk)
        (!i_rst_n || $rose(i_rst_n)) |-> (!i_in_ack && !i_descriptor_wr && i_descriptor == '0))
        else begin $error("outputs active during reset"); fail_count++; end
    a_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_in_ack) |-> $past(i_in_req))
        else begin $error("ack rose without req"); fail_count++; end
    a_ack_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!i_in_req && !i_in_ack) |=> !i_in_ack)
        else begin $error("ack rose while req low"); fail_count++; end
    a_ack_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_in_ack && i_in_req) |=> i_in_ack)
        else begin $error("ack dropped before req"); fail_count++; end
    a_ack_fall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_in_ack && !i_in_req) |=> !i_in_ack)
        else begin $error("ack late after req fell"); fail_count++; end

    //******************************************************************
    // output strobe and priority
    //******************************************************************
    a_wr_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_descriptor_wr |=> !i_descriptor_wr)
        else begin $error("write strobe longer than one cycle"); fail_count++; end
    a_wr_needs_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        wait_ready |-> !i_descriptor_wr)
        else begin $error("new strobe before host ready"); fail_count++; end
    a_ts_first: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_fifo_rd |-> !$past(i_ts_due_any))
        else begin $error("fifo read while ts entry due"); fail_count++; end
    a_ts_rd_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ts_rd |=> !i_ts_rd)
        else begin $error("ts read strobe longer than one cycle"); fail_count++; end

endmodule

bind host_queue_top host_queue_properties u_props (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_in_req(i_in_req), .i_in_ack(o_in_ack),
    .i_descriptor(o_descriptor), .i_descriptor_wr(o_descriptor_wr),
    .i_descriptor_ready(i_descriptor_ready), .i_fifo_rd(fifo_rd),
    .i_ts_rd(ts_rd), .i_ts_due_any(ts_due_any)
);

// File: verif/tb_host_queue.sv
/* host queue testbench */

module tb_host_queue;

    localparam int CLK_HALF = 50;
    localparam logic [31:0] SEED = 32'd29017;
    // phase lengths in cycles
    localparam int PH_ORDER = 200;
    localparam int PH_TS    = 700;
    localparam int PH_BP    = 600;
    localparam int PH_PRIO  = 300;
    localparam int PH_DRAIN = 200;
    localparam int TIMEOUT  = 2 * (PH_ORDER + PH_TS + PH_BP + PH_PRIO + PH_DRAIN);

    logic                       i_clk;
    logic                       i_rst_n;
    logic                       i_in_req;
    logic [hq_pkg::DESC_W-1:0]  i_in_desc;
    logic                       o_in_ack;
    logic [hq_pkg::DESC_W-1:0]  o_descriptor;
    logic                       o_descriptor_wr;
    logic                       i_descriptor_ready = 1'b1;

    logic [31:0]                stim_rng;
    logic [31:0]                ready_rng = SEED;
    int                         cyc = 0;
    int                         total_cyc = 0;
    int                         data_errs = 0;
    int                         other_errs = 0;
    int                         ready_mode = 0;
    int                         low_left = 0;
    string                      test_name = "reset";
    logic                       ack_seen = 1'b0;
    // reference model
    logic [hq_pkg::DESC_W-1:0]  exp_q [$];
    logic [hq_pkg::DESC_W-1:0]  ts_desc [hq_pkg::N_SLOTS];
    logic [hq_pkg::N_SLOTS-1:0] ts_pend = '0;
    logic [hq_pkg::N_SLOTS-1:0] ts_ticked = '0;
    logic [hq_pkg::N_SLOTS-1:0] due_prev1 = '0;
    logic [hq_pkg::N_SLOTS-1:0] due_prev2 = '0;

    host_queue_top DUT (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_in_req(i_in_req), .i_in_desc(i_in_desc),
        .o_in_ack(o_in_ack), .o_descriptor(o_descriptor), .o_descriptor_wr(o_descriptor_wr),
        .i_descriptor_ready(i_descriptor_ready)
    );

    initial begin
        i_clk = 1'b0;
        forever #CLK_HALF i_clk = ~i_clk;
    end

    function automatic logic [31:0] lcg_step(inout logic [31:0] st);
        st = st * 32'd1103515245 + 32'd12345;
        return st;
    endfunction

    // type, slot, then 17 random bits of length and buffer id
    function automatic logic [hq_pkg::DESC_W-1:0] make_desc(input logic [2:0] t,
                                                            input logic [2:0] s);
        logic [31:0] r;
        r = lcg_step(stim_rng);
        return {t, s, r[30:14]};
    endfunction

    function automatic logic [hq_pkg::TYPE_W-1:0] pick_non_ts();
        logic [31:0] r;
        r = lcg_step(stim_rng);
        case (r[17:16])
            2'd0: return hq_pkg::PKT_BE;
            2'd1: return hq_pkg::PKT_RC;
            default: return hq_pkg::PKT_PTP;
        endcase
    endfunction

    // random slot, moved on past pending ones
    function automatic logic [hq_pkg::SLOT_W-1:0] pick_free_slot();
        logic [hq_pkg::SLOT_W-1:0] s;
        s = hq_pkg::SLOT_W'(lcg_step(stim_rng) >> 16);
        for (int i = 0; i < hq_pkg::N_SLOTS; i++) begin
            if (ts_pend[s]) begin
                s = s + 1'b1;
            end
        end
        return s;
    endfunction

    task automatic send_desc(input logic [hq_pkg::DESC_W-1:0] d);
        @(negedge i_clk);
        i_in_desc = d;
        i_in_req  = 1'b1;
        while (!o_in_ack) @(negedge i_clk);
        i_in_req = 1'b0;
        while (o_in_ack) @(negedge i_clk);
    endtask

    task automatic send_non_ts(input int n);
        repeat (n) send_desc(make_desc(pick_non_ts(), 3'(lcg_step(stim_rng) >> 20)));
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || ts_pend != '0) @(negedge i_clk);
        repeat (4) @(negedge i_clk);
    endtask

    //******************************************************************
    // scoreboard
    //******************************************************************
    task automatic check_output();
        logic [hq_pkg::DESC_W-1:0] exp;
        logic [hq_pkg::SLOT_W-1:0] s;
        logic                      found;
        if (o_descriptor[hq_pkg::TYPE_LSB +: hq_pkg::TYPE_W] == hq_pkg::PKT_TS) begin
            if (due_prev1 == '0) begin
                $display("%s: ts descriptor %h sent with no slot due", test_name, o_descriptor);
                other_errs++;
            end else begin
                // ascending slot order, first due slot wins
                s     = '0;
                found = 1'b0;
                for (int i = 0; i < hq_pkg::N_SLOTS; i++) begin
                    if (due_prev1[i] && !found) begin
                        s     = hq_pkg::SLOT_W'(i);
                        found = 1'b1;
                    end
                end
                exp = ts_desc[s];
                assert (o_descriptor == exp) else begin
                    $display("Mismatch %s: expected %h actual %h", test_name, exp, o_descriptor);
                    data_errs++;
                end
                ts_pend[s]   = 1'b0;
                ts_ticked[s] = 1'b0;
            end
        end else if (due_prev2 != '0) begin
            $display("%s: fifo descriptor sent while a ts entry was due", test_name);
            other_errs++;
        end else if (exp_q.size() == 0) begin
            $display("%s: unexpected descriptor %h on output", test_name, o_descriptor);
            other_errs++;
        end else begin
            exp = exp_q.pop_front();
            assert (o_descriptor == exp) else begin
                $display("Mismatch %s: expected %h actual %h", test_name, exp, o_descriptor);
                data_errs++;
            end
        end
    endtask

    // samples state after edge cyc, before the counter moves on
    always @(posedge i_clk) begin
        logic [hq_pkg::SLOT_W-1:0] slot;
        if (i_rst_n && cyc > 0) begin
            // tick from the previous edge marks an already pending slot due
            if (cyc > hq_pkg::SLOT_CYCLES && (cyc - 1) % hq_pkg::SLOT_CYCLES == 0) begin
                slot = hq_pkg::SLOT_W'(((cyc - 1) / hq_pkg::SLOT_CYCLES) % hq_pkg::N_SLOTS);
                if (ts_pend[slot]) begin
                    ts_ticked[slot] = 1'b1;
                end
            end
            if (o_in_ack && !ack_seen) begin
                if (i_in_desc[hq_pkg::TYPE_LSB +: hq_pkg::TYPE_W] == hq_pkg::PKT_TS) begin
                    slot = i_in_desc[hq_pkg::SLOT_LSB +: hq_pkg::SLOT_W];
                    ts_desc[slot]   = i_in_desc;
                    ts_pend[slot]   = 1'b1;
                    ts_ticked[slot] = 1'b0;
                end else begin
                    exp_q.push_back(i_in_desc);
                end
            end
            ack_seen = o_in_ack;
            if (o_descriptor_wr) begin
                check_output();
            end
            due_prev2 = due_prev1;
            due_prev1 = ts_pend & ts_ticked;
        end
        if (i_rst_n) begin
            cyc++;
        end
    end

    // host ready, 0 high, 1 random low stretches, 2 held low
    always @(negedge i_clk) begin
        logic [31:0] r;
        if (ready_mode == 2) begin
            i_descriptor_ready = 1'b0;
        end else if (ready_mode == 1 && low_left > 0) begin
            i_descriptor_ready = 1'b0;
            low_left--;
        end else if (ready_mode == 1) begin
            i_descriptor_ready = 1'b1;
            r = lcg_step(ready_rng);
            if (r[18:16] < 3'd3) begin
                low_left = int'(r[23:20]) + 2;
            end
        end else begin
            i_descriptor_ready = 1'b1;
        end
    end

    always @(posedge i_clk) begin
        total_cyc++;
        if (total_cyc >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    //******************************************************************
    // stimulus
    //******************************************************************
    initial begin
        logic [hq_pkg::SLOT_W-1:0] s;
        logic [31:0]               r;
        i_rst_n   = 1'b0;
        i_in_req  = 1'b0;
        i_in_desc = '0;
        stim_rng  = SEED;
        repeat (3) @(negedge i_clk);
        i_rst_n = 1'b1;

        test_name = "non-ts order";
        send_non_ts(20);
        wait_drain();

        // about one in four ts
        test_name = "ts release";
        repeat (16) begin
            r = lcg_step(stim_rng);
            if (r[17:16] == 2'd0) begin
                send_desc(make_desc(hq_pkg::PKT_TS, pick_free_slot()));
            end else begin
                send_non_ts(1);
            end
        end
        wait_drain();

        // held low fills the fifo, the extra send stalls until ready returns
        test_name = "back-pressure";
        ready_mode <= 2;
        send_non_ts(hq_pkg::FIFO_DEPTH + 1);
        fork
            send_non_ts(2);
            begin
                repeat (20) @(negedge i_clk);
                ready_mode <= 1;
            end
        join
        send_non_ts(20);
        wait_drain();

        // ts comes due behind a full output and a loaded fifo
        test_name = "priority";
        ready_mode <= 2;
        send_non_ts(4);
        s = hq_pkg::SLOT_W'((cyc / hq_pkg::SLOT_CYCLES + 2) % hq_pkg::N_SLOTS);
        send_desc(make_desc(hq_pkg::PKT_TS, s));
        while (!ts_ticked[s]) @(negedge i_clk);
        ready_mode <= 0;
        wait_drain();

        $display("errors: data %0d, other %0d, assertion %0d",
                 data_errs, other_errs, DUT.u_props.fail_count);
        if (data_errs + other_errs + DUT.u_props.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
src/hq_pkg.sv
src/host_input_queue.sv
src/descriptor_fifo.sv
src/ts_slot_table.sv
src/slot_timer.sv
src/host_output_queue.sv
src/host_queue_top.sv
verif/host_queue_properties.sv
verif/tb_host_queue.sv

// File: run_sim.sh
#!/bin/sh
# build and run the host queue testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_host_queue
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_host_queue +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
